//--- files.f
source/mipsPkg.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/datapath.sv
tests/datapath_assertions.sv
tests/datapathTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module datapathTb -f files.f -o simv
out=$(./obj_dir/simv +verilator+error+limit+100 || true)
echo "$out"
echo "$out" | grep -q "^NO ERRORS$"

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic arstN,
	output logic [31:0] pc,
	input logic [31:0] instr,
	output mipsPkg::wbMasterT wbOut,
	input logic wbAck,
	input logic [31:0] wbDatR,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	import mipsPkg::*;

	decodedInstrT decoded;
	execResultT result;
	redirectT redirect;
	forwardT forward;
	// memory wait from the result stage
	logic stall;
	logic [4:0] rfAddrA;
	logic [4:0] rfAddrB;
	logic [31:0] rfDataA;
	logic [31:0] rfDataB;
	logic rfWe;
	logic [4:0] rfWaddr;
	logic [31:0] rfWdata;

	////////////////////
	// stages
	decodeStage #(
		.resetPc(resetPc)
	) u_decode (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.instr(instr),
		.redirect(redirect),
		.pc(pc),
		.rfAddrA(rfAddrA),
		.rfAddrB(rfAddrB),
		.rfDataA(rfDataA),
		.rfDataB(rfDataB),
		.decoded(decoded)
	);

	executeStage u_execute (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.decoded(decoded),
		.forward(forward),
		.redirect(redirect),
		.result(result)
	);

	resultStage u_result (
		.clk(clk),
		.arstN(arstN),
		.result(result),
		.wbOut(wbOut),
		.wbAck(wbAck),
		.wbDatR(wbDatR),
		.stall(stall),
		.forward(forward),
		.rfWe(rfWe),
		.rfWaddr(rfWaddr),
		.rfWdata(rfWdata),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	// read in decode, written from result
	regFile u_regFile (
		.clk(clk),
		.raddrA(rfAddrA),
		.raddrB(rfAddrB),
		.we(rfWe),
		.waddr(rfWaddr),
		.wdata(rfWdata),
		.rdataA(rfDataA),
		.rdataB(rfDataB)
	);

endmodule

//--- source/decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic [31:0] instr,
	input mipsPkg::redirectT redirect,
	output logic [31:0] pc,
	output logic [4:0] rfAddrA,
	output logic [4:0] rfAddrB,
	input logic [31:0] rfDataA,
	input logic [31:0] rfDataB,
	output mipsPkg::decodedInstrT decoded
);
	import mipsPkg::*;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ = 6'h02,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddiu = 6'h09,
		opOri = 6'h0d,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		fnMfhi = 6'h10,
		fnMflo = 6'h12,
		fnMultu = 6'h19,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functE;

	logic [31:0] instrWord;
	logic [31:0] pcD;
	logic validD;
	logic [31:0] pcPlus4;
	opcodeE op;
	functE fn;

	////////////////////
	// pc and fetch capture

	// a taken redirect squashes the word fetched alongside it
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= resetPc;
			validD <= 1'b0;
		end else if (!stall) begin
			pc <= redirect.taken ? redirect.target : pc + 32'd4;
			validD <= !redirect.taken;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instrWord <= instr;
			pcD <= pc;
		end
	end

	////////////////////
	// field extraction
	assign op = opcodeE'(instrWord[31:26]);
	assign fn = functE'(instrWord[5:0]);
	assign pcPlus4 = pcD + 32'd4;
	assign rfAddrA = instrWord[25:21];
	assign rfAddrB = instrWord[20:16];

	always_comb begin
		decoded = '0;
		decoded.valid = validD;
		decoded.pc = pcD;
		decoded.rs = instrWord[25:21];
		decoded.rt = instrWord[20:16];
		decoded.rsVal = rfDataA;
		decoded.rtVal = rfDataB;
		// sign extend unless overridden below
		decoded.imm = {{16{instrWord[15]}}, instrWord[15:0]};
		// region of the delay slot
		decoded.jumpTarget = {pcPlus4[31:28], instrWord[25:0], 2'b00};
		// i-type writes rt
		decoded.dest = instrWord[20:16];
		case (op)
			opSpecial: begin
				decoded.dest = instrWord[15:11];
				decoded.regWrite = 1'b1;
				case (fn)
					fnAddu: decoded.aluOp = aluAdd;
					fnSubu: decoded.aluOp = aluSub;
					fnAnd: decoded.aluOp = aluAnd;
					fnOr: decoded.aluOp = aluOr;
					fnSlt: decoded.aluOp = aluSlt;
					fnMfhi: decoded.aluOp = aluPassHi;
					fnMflo: decoded.aluOp = aluPassLo;
					fnMultu: begin
						// only hi/lo change
						decoded.aluOp = aluMultu;
						decoded.regWrite = 1'b0;
					end
					// nop and anything unsupported
					default: decoded.regWrite = 1'b0;
				endcase
			end
			opAddiu: begin
				decoded.useImm = 1'b1;
				decoded.regWrite = 1'b1;
			end
			opOri: begin
				decoded.aluOp = aluOr;
				decoded.useImm = 1'b1;
				decoded.imm = {16'd0, instrWord[15:0]};
				decoded.regWrite = 1'b1;
			end
			opLui: begin
				decoded.aluOp = aluLui;
				decoded.useImm = 1'b1;
				decoded.imm = {instrWord[15:0], 16'd0};
				decoded.regWrite = 1'b1;
			end
			// address is rs + imm
			opLw: begin
				decoded.useImm = 1'b1;
				decoded.memRead = 1'b1;
				decoded.regWrite = 1'b1;
			end
			opSw: begin
				decoded.useImm = 1'b1;
				decoded.memWrite = 1'b1;
			end
			opBeq: decoded.isBranch = 1'b1;
			opBne: begin
				decoded.isBranch = 1'b1;
				decoded.branchNe = 1'b1;
			end
			opJ: decoded.isJump = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input logic clk,
	input logic arstN,
	input logic stall,
	input mipsPkg::decodedInstrT decoded,
	input mipsPkg::forwardT forward,
	output mipsPkg::redirectT redirect,
	output mipsPkg::execResultT result
);
	import mipsPkg::*;

	decodedInstrT ex;
	logic [31:0] opA;
	logic [31:0] rtOp;
	logic [31:0] opB;
	logic [31:0] aluOut;
	logic [31:0] hiReg;
	logic [31:0] loReg;
	logic [63:0] product;
	logic operandsEqual;

	// r0 first, then the write-back of this cycle, then the decode copy
	function automatic logic [31:0] pickOperand(
		input logic [4:0] num,
		input logic [31:0] captured,
		input forwardT fw
	);
		if (num == 5'd0)
			return 32'd0;
		if (fw.valid && fw.dest == num)
			return fw.value;
		return captured;
	endfunction

	////////////////////
	// pipeline register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			ex <= '0;
		else if (!stall)
			ex <= decoded;
	end

	assign opA = pickOperand(ex.rs, ex.rsVal, forward);
	assign rtOp = pickOperand(ex.rt, ex.rtVal, forward);
	assign opB = ex.useImm ? ex.imm : rtOp;

	////////////////////
	// multiplier and hi/lo

	// unsigned 64-bit product
	assign product = {32'd0, opA} * {32'd0, rtOp};

	// written as multu leaves, so a following mfhi sees it
	always_ff @(posedge clk) begin
		if (!stall && ex.valid && ex.aluOp == aluMultu)
			{hiReg, loReg} <= product;
	end

	// alu
	always_comb begin
		case (ex.aluOp)
			aluAdd: aluOut = opA + opB;
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			aluSlt: aluOut = {31'd0, $signed(opA) < $signed(opB)};
			aluLui: aluOut = opB;
			aluPassHi: aluOut = hiReg;
			aluPassLo: aluOut = loReg;
			default: aluOut = product[31:0];
		endcase
	end

	////////////////////
	// branch decision
	assign operandsEqual = opA == rtOp;
	assign redirect.taken = ex.valid &&
		(ex.isJump || (ex.isBranch && (operandsEqual != ex.branchNe)));
	// pc+4 plus word offset
	assign redirect.target = ex.isJump ? ex.jumpTarget :
		ex.pc + 32'd4 + {ex.imm[29:0], 2'b00};

	// toward the result stage
	always_comb begin
		result.valid = ex.valid;
		result.pc = ex.pc;
		result.aluOut = aluOut;
		result.storeData = rtOp;
		result.dest = ex.dest;
		result.regWrite = ex.regWrite;
		result.memRead = ex.memRead;
		result.memWrite = ex.memWrite;
		if (ex.memRead)
			result.resultSel = selMem;
		else if (ex.regWrite)
			result.resultSel = selAlu;
		else
			result.resultSel = selNone;
	end

endmodule

//--- source/mipsPkg.sv
package mipsPkg;

	////////////////////
	// execute operations

	// passHi / passLo serve mfhi and mflo
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui,
		aluMultu,
		aluPassHi,
		aluPassLo
	} aluOpE;

	// write-back source
	typedef enum logic [1:0] {
		selAlu,
		selMem,
		selNone
	} resultSelE;

	////////////////////
	// stage bundles

	// decode to execute
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		aluOpE aluOp;
		logic useImm;
		// already extended, or shifted up for lui
		logic [31:0] imm;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] dest;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic branchNe;
		logic isJump;
		logic [31:0] jumpTarget;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
	} decodedInstrT;

	// execute to result
	typedef struct packed {
		logic valid;
		logic [31:0] pc;
		logic [31:0] aluOut;
		logic [31:0] storeData;
		logic [4:0] dest;
		logic regWrite;
		logic memRead;
		logic memWrite;
		resultSelE resultSel;
	} execResultT;

	// execute back to decode
	typedef struct packed {
		logic taken;
		logic [31:0] target;
	} redirectT;

	// result back to execute, the write of this cycle
	typedef struct packed {
		logic valid;
		logic [4:0] dest;
		logic [31:0] value;
	} forwardT;

	// wishbone classic master outputs
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [31:0] adr;
		logic [31:0] datW;
	} wbMasterT;

endpackage

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic [4:0] raddrA,
	input logic [4:0] raddrB,
	input logic we,
	input logic [4:0] waddr,
	input logic [31:0] wdata,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB
);

	logic [31:0] regs [32];

	// r0 hard zero, same-cycle write shows through
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0;
		if (we && waddr == addr)
			return wdata;
		return regs[addr];
	endfunction

	// r0 never stored
	always_ff @(posedge clk) begin
		if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	assign rdataA = readPort(raddrA);
	assign rdataB = readPort(raddrB);

endmodule

//--- source/resultStage.sv
`timescale 1ns/1ps

module resultStage (
	input logic clk,
	input logic arstN,
	input mipsPkg::execResultT result,
	output mipsPkg::wbMasterT wbOut,
	input logic wbAck,
	input logic [31:0] wbDatR,
	output logic stall,
	output mipsPkg::forwardT forward,
	output logic rfWe,
	output logic [4:0] rfWaddr,
	output logic [31:0] rfWdata,
	output logic [31:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	import mipsPkg::*;

	execResultT res;
	logic memAccess;

	// held in place while the bus cycle is open
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			res <= '0;
		else if (!stall)
			res <= result;
	end

	////////////////////
	// wishbone data cycle
	assign memAccess = res.valid && (res.memRead || res.memWrite);
	// whole pipe waits for ack
	assign stall = memAccess && !wbAck;

	assign wbOut.cyc = memAccess;
	assign wbOut.stb = memAccess;
	assign wbOut.we = res.valid && res.memWrite;
	// word accesses only
	assign wbOut.sel = 4'b1111;
	assign wbOut.adr = res.aluOut;
	assign wbOut.datW = res.storeData;

	////////////////////
	// write-back

	// a load writes in its ack cycle
	assign rfWe = res.valid && res.regWrite && !stall;
	assign rfWaddr = res.dest;
	assign rfWdata = (res.resultSel == selMem) ? wbDatR : res.aluOut;

	assign forward.valid = rfWe;
	assign forward.dest = rfWaddr;
	assign forward.value = rfWdata;

	// debug trace
	assign debugWbPc = res.pc;
	assign debugWbRfWen = {4{rfWe}};
	assign debugWbRfWnum = rfWaddr;
	assign debugWbRfWdata = rfWdata;

endmodule

//--- tests/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;
	import mipsPkg::*;

	localparam int resetCycles = 16;
	localparam int romWords = 64;
	// six cycles per rom word covers every wait state
	localparam int watchdogCycles = resetCycles + romWords * 6;

	logic clk = 1'b0;
	logic arstN;
	logic [31:0] pc;
	logic [31:0] instr;
	wbMasterT wbOut;
	logic wbAck;
	logic [31:0] wbDatR;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] rom [romWords];
	logic [31:0] dataMem [64];
	logic [31:0] rngState;
	logic pending;
	logic [1:0] waitCnt;

	always #4 clk = ~clk;

	datapath #(
		.resetPc(32'h0000_0000)
	) i_dut (
		.clk(clk),
		.arstN(arstN),
		.pc(pc),
		.instr(instr),
		.wbOut(wbOut),
		.wbAck(wbAck),
		.wbDatR(wbDatR),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	////////////////////
	// program
	initial begin
		for (int i = 0; i < romWords; i++)
			rom[i] = 32'd0;
		rom[0] = encI(6'h09, 5'd0, 5'd1, 16'h0005);
		rom[1] = encI(6'h09, 5'd0, 5'd2, 16'h0007);
		// distance 1 and 2 operands
		rom[2] = encR(5'd1, 5'd2, 5'd3, 6'h21);
		rom[3] = encR(5'd3, 5'd1, 5'd4, 6'h23);
		rom[4] = encI(6'h0f, 5'd0, 5'd5, 16'h1234);
		rom[5] = encI(6'h0d, 5'd5, 5'd5, 16'h5678);
		rom[6] = encR(5'd5, 5'd3, 5'd6, 6'h24);
		rom[7] = encR(5'd5, 5'd1, 5'd7, 6'h25);
		rom[8] = encR(5'd4, 5'd3, 5'd8, 6'h2a);
		rom[9] = encI(6'h09, 5'd0, 5'd9, 16'hffff);
		rom[10] = encR(5'd9, 5'd1, 5'd10, 6'h2a);
		// store then load back, same word
		rom[11] = encI(6'h2b, 5'd0, 5'd5, 16'h0010);
		rom[12] = encI(6'h23, 5'd0, 5'd11, 16'h0010);
		rom[13] = encR(5'd11, 5'd1, 5'd12, 6'h21);
		// taken beq to word 17, slot at 15
		rom[14] = encI(6'h04, 5'd1, 5'd1, 16'h0002);
		rom[15] = encI(6'h09, 5'd0, 5'd13, 16'h0033);
		rom[16] = encI(6'h09, 5'd0, 5'd14, 16'h0044);
		rom[17] = encI(6'h05, 5'd1, 5'd1, 16'h0005);
		rom[18] = encI(6'h09, 5'd0, 5'd15, 16'h0055);
		rom[19] = encI(6'h09, 5'd0, 5'd16, 16'h0066);
		rom[20] = {6'h02, 26'd23};
		rom[21] = encI(6'h09, 5'd0, 5'd17, 16'h0077);
		rom[22] = encI(6'h09, 5'd0, 5'd18, 16'h0088);
		rom[23] = encR(5'd5, 5'd9, 5'd0, 6'h19);
		rom[24] = encR(5'd0, 5'd0, 5'd20, 6'h10);
		rom[25] = encR(5'd0, 5'd0, 5'd21, 6'h12);
		rom[26] = encI(6'h2b, 5'd0, 5'd21, 16'h0014);
		rom[27] = encI(6'h23, 5'd0, 5'd22, 16'h0014);
		// parks here, slot 29 is a nop
		rom[28] = {6'h02, 26'd28};
		for (int i = 0; i < 64; i++)
			dataMem[i] = 32'hc0de_0000 ^ (i * 32'h0101_0101);
	end

	// combinational fetch
	assign instr = rom[pc[7:2]];

	////////////////////
	// wishbone slave
	always @(posedge clk) begin
		rngState <= xorshift(rngState);
		if (wbAck) begin
			wbAck <= 1'b0;
			pending <= 1'b0;
		end else if (wbOut.cyc && wbOut.stb) begin
			// draw a wait count at the start of each cycle
			if ((!pending && rngState[1:0] == 2'd0) || (pending && waitCnt == 2'd0)) begin
				wbAck <= 1'b1;
				wbDatR <= dataMem[wbOut.adr[7:2]];
				if (wbOut.we)
					dataMem[wbOut.adr[7:2]] <= wbOut.datW;
			end else if (!pending) begin
				pending <= 1'b1;
				waitCnt <= rngState[1:0] - 2'd1;
			end else begin
				waitCnt <= waitCnt - 2'd1;
			end
		end
	end

	// reset and start values
	initial begin
		arstN = 1'b0;
		wbAck = 1'b0;
		wbDatR = 32'd0;
		pending = 1'b0;
		waitCnt = 2'd0;
		rngState = 32'hbbd42a97;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
	end

	initial begin
		#(watchdogCycles * 8);
		$display("watchdog expired before the program finished");
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

	////////////////////
	// verdict
	initial begin
		wait (arstN);
		while (!i_dut.chk.done && !i_dut.chk.failed)
			@(negedge clk);
		// a little tail to catch stray writes
		for (int i = 0; i < 10 && !i_dut.chk.failed; i++)
			@(negedge clk);
		if (i_dut.chk.failed) begin
			$display("ERRORS FOUND");
			$fatal(1, "assertion failure");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

//--- tests/datapath_assertions.sv
`timescale 1ns/1ps

module datapathAssertions #(
	parameter logic [31:0] resetPc = 32'h0000_0000
) (
	input logic clk,
	input logic arstN,
	input logic [31:0] pc,
	input mipsPkg::wbMasterT wbOut,
	input logic wbAck,
	input logic [31:0] debugWbPc,
	input logic [3:0] debugWbRfWen,
	input logic [4:0] debugWbRfWnum,
	input logic [31:0] debugWbRfWdata
);
	import mipsPkg::*;

	localparam int nExp = 20;

	// {register, value} in program order
	localparam logic [36:0] expTable [nExp] = '{
		{5'd1, 32'h0000_0005}, {5'd2, 32'h0000_0007}, {5'd3, 32'h0000_000c},
		{5'd4, 32'h0000_0007}, {5'd5, 32'h1234_0000}, {5'd5, 32'h1234_5678},
		{5'd6, 32'h0000_0008}, {5'd7, 32'h1234_567d}, {5'd8, 32'h0000_0001},
		{5'd9, 32'hffff_ffff}, {5'd10, 32'h0000_0001}, {5'd11, 32'h1234_5678},
		{5'd12, 32'h1234_567d}, {5'd13, 32'h0000_0033}, {5'd15, 32'h0000_0055},
		{5'd16, 32'h0000_0066}, {5'd17, 32'h0000_0077}, {5'd20, 32'h1234_5677},
		{5'd21, 32'hedcb_a988}, {5'd22, 32'hedcb_a988}
	};

	// pc of each write-back, skipped slots leave gaps
	localparam logic [31:0] expPc [nExp] = '{
		32'h0000_0000, 32'h0000_0004, 32'h0000_0008, 32'h0000_000c, 32'h0000_0010,
		32'h0000_0014, 32'h0000_0018, 32'h0000_001c, 32'h0000_0020, 32'h0000_0024,
		32'h0000_0028, 32'h0000_0030, 32'h0000_0034, 32'h0000_003c, 32'h0000_0048,
		32'h0000_004c, 32'h0000_0054, 32'h0000_0060, 32'h0000_0064, 32'h0000_006c
	};

	int idx;
	logic done;
	logic failed;
	logic [36:0] expWb;
	logic [31:0] expWbPc;
	logic wbFail = 1'b0;
	logic pcFail = 1'b0;
	logic extraFail = 1'b0;
	logic busFail = 1'b0;
	logic shapeFail = 1'b0;
	logic waitFail = 1'b0;
	logic resetFail = 1'b0;

	// one step per write-back
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			idx <= 0;
		else if (debugWbRfWen != 4'd0 && idx < nExp)
			idx <= idx + 1;
	end

	assign done = idx == nExp;
	assign failed = wbFail | pcFail | extraFail | busFail | shapeFail | waitFail | resetFail;

	// entry due next
	assign expWb = (idx < nExp) ? expTable[idx] : '0;
	assign expWbPc = (idx < nExp) ? expPc[idx] : '0;

	////////////////////
	// write-back order
	wbValue: assert property (@(posedge clk) disable iff (!arstN)
		(debugWbRfWen != 4'd0 && idx < nExp) |->
			(debugWbRfWen == 4'hf && {debugWbRfWnum, debugWbRfWdata} == expWb))
		else begin
			wbFail = 1'b1;
			$error("ERR debugWbRfWen/Wnum/Wdata got %h/%h/%h expected f/%h/%h",
				$sampled(debugWbRfWen), $sampled(debugWbRfWnum),
				$sampled(debugWbRfWdata), $sampled(expWb[36:32]), $sampled(expWb[31:0]));
		end

	wbPc: assert property (@(posedge clk) disable iff (!arstN)
		(debugWbRfWen != 4'd0 && idx < nExp) |-> debugWbPc == expWbPc)
		else begin
			pcFail = 1'b1;
			$error("ERR debugWbPc got %h expected %h",
				$sampled(debugWbPc), $sampled(expWbPc));
		end

	// nothing past the table, skipped slots included
	wbExtra: assert property (@(posedge clk) disable iff (!arstN)
		(debugWbRfWen != 4'd0) |-> idx < nExp)
		else begin
			extraFail = 1'b1;
			$error("a write-back appeared after the last expected one");
		end

	////////////////////
	// bus rules
	busHold: assert property (@(posedge clk) disable iff (!arstN)
		(wbOut.cyc && !wbAck) |=>
			(wbOut.cyc && $stable(wbOut.adr) && $stable(wbOut.we) &&
				$stable(wbOut.sel) && $stable(wbOut.datW)))
		else begin
			busFail = 1'b1;
			$error("bus cycle dropped or changed its request before ack");
		end

	// stb follows cyc, word selects only
	busShape: assert property (@(posedge clk) disable iff (!arstN)
		wbOut.stb == wbOut.cyc && (!wbOut.cyc || wbOut.sel == 4'hf))
		else begin
			shapeFail = 1'b1;
			$error("ERR wbOut.cyc/stb/sel got %h/%h/%h expected stb equal to cyc and sel f",
				$sampled(wbOut.cyc), $sampled(wbOut.stb), $sampled(wbOut.sel));
		end

	waitNoWb: assert property (@(posedge clk) disable iff (!arstN)
		(wbOut.cyc && !wbAck) |-> debugWbRfWen == 4'd0)
		else begin
			waitFail = 1'b1;
			$error("ERR debugWbRfWen got %h expected 0 while waiting for ack",
				$sampled(debugWbRfWen));
		end

	// in reset and on the first edge after it
	resetPcHeld: assert property (@(posedge clk)
		(!arstN || $rose(arstN)) |-> pc == resetPc)
		else begin
			resetFail = 1'b1;
			$error("ERR pc got %h expected %h", $sampled(pc), resetPc);
		end

	resetQuiet: assert property (@(posedge clk)
		(!arstN || $rose(arstN)) |-> (!wbOut.cyc && debugWbRfWen == 4'd0))
		else begin
			resetFail = 1'b1;
			$error("bus cycle or write-back active during or right after reset");
		end

endmodule

bind datapath datapathAssertions #(
	.resetPc(resetPc)
) chk (
	.clk(clk),
	.arstN(arstN),
	.pc(pc),
	.wbOut(wbOut),
	.wbAck(wbAck),
	.debugWbPc(debugWbPc),
	.debugWbRfWen(debugWbRfWen),
	.debugWbRfWnum(debugWbRfWnum),
	.debugWbRfWdata(debugWbRfWdata)
);
